// File: Makefile
# Verilator flow for the lz77 compressor, all variables can be overridden
VERILATOR  ?= verilator
FILELIST   ?= filelist.f
TB_TOP     ?= lz77_tb
RTL_TOP    ?= lz77_top
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS ?= --lint-only -Wall
SIM_ARGS   ?= +verilator+error+limit+100
FAIL_MSG   ?= *** FAILED ***
PASS_MSG   ?= *** PASSED ***

RTL_SRCS := $(shell grep '^hdl/' $(FILELIST))
ALL_SRCS := $(shell cat $(FILELIST))
SIM_BIN  := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

$(SIM_BIN): $(ALL_SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

sim: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -qF '$(PASS_MSG)' $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: filelist.f
hdl/lz77_pkg.sv
hdl/lz77_fetch.sv
hdl/lz77_buffer.sv
hdl/lz77_match.sv
hdl/lz77_ctrl.sv
hdl/lz77_top.sv
sim/lz77_asserts.sv
sim/lz77_tb.sv

// File: hdl/lz77_buffer.sv
// history window and lookahead store for the lz77 compressor
// both are shift arrays, index 0 is the newest history byte
// and the oldest lookahead byte
// fill counts for both, cleared at block start

`timescale 1ns/1ps
`default_nettype none

module lz77_buffer #(
  parameter int WIN_SIZE = lz77_pkg::DEF_WIN_SIZE,
  parameter int MAX_LEN  = lz77_pkg::DEF_MAX_LEN
) (
  input  logic                                clk,
  input  logic                                rstn,
  input  logic                                start_i,
  input  logic                                push_i,
  input  lz77_pkg::byte_t                     dat_i,
  input  logic                                shift_i,
  output lz77_pkg::byte_t [WIN_SIZE-1:0]      hist_o,
  output lz77_pkg::byte_t [MAX_LEN-1:0]       la_o,
  output lz77_pkg::dst_t                      win_cnt_o,
  output lz77_pkg::len_t                      la_cnt_o
);

  import lz77_pkg::*;

  byte_t [WIN_SIZE-1:0] hist_q;
  byte_t [MAX_LEN-1:0]  la_q;
  dst_t                 win_cnt_q;
  len_t                 la_cnt_q;
  logic                 blk_start;

  // a start with live lookahead belongs to a running block
  assign blk_start = start_i && (la_cnt_q == '0);

  //----------------------------------------------------------
  // fill counts
  //----------------------------------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      win_cnt_q <= '0;
      la_cnt_q  <= '0;
    end else if (blk_start) begin
      win_cnt_q <= '0;
      la_cnt_q  <= '0;
    end else if (shift_i) begin
      la_cnt_q <= la_cnt_q - len_t'(1);
      // history saturates at the window depth
      if (win_cnt_q < dst_t'(WIN_SIZE)) begin
        win_cnt_q <= win_cnt_q + dst_t'(1);
      end
    end else if (push_i) begin
      la_cnt_q <= la_cnt_q + len_t'(1);
    end
  end

  //----------------------------------------------------------
  // byte storage
  //----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (shift_i) begin
      // oldest lookahead byte becomes distance 1
      hist_q <= {hist_q[WIN_SIZE-2:0], la_q[0]};
      la_q   <= {byte_t'(0), la_q[MAX_LEN-1:1]};
    end else if (push_i) begin
      // append behind the last valid lookahead byte
      for (int i = 0; i < MAX_LEN; i++) begin
        if (la_cnt_q == len_t'(i)) begin
          la_q[i] <= dat_i;
        end
      end
    end
  end

  assign hist_o    = hist_q;
  assign la_o      = la_q;
  assign win_cnt_o = win_cnt_q;
  assign la_cnt_o  = la_cnt_q;

endmodule

`default_nettype wire

// File: hdl/lz77_ctrl.sv
// block control for the lz77 compressor
// fsm over update, search, emit and shift
// token register, consumed byte count and output strobes

`timescale 1ns/1ps
`default_nettype none

module lz77_ctrl (
  input  logic               clk,
  input  logic               rstn,
  input  logic               start_i,
  input  lz77_pkg::blk_len_t cfg_len_i,
  input  logic               fill_done_i,
  input  logic               srch_done_i,
  input  lz77_pkg::len_t     best_len_i,
  input  lz77_pkg::dst_t     best_dst_i,
  input  logic               is_lit_i,
  input  lz77_pkg::byte_t    la_i,
  output logic               fill_en_o,
  output logic               srch_go_o,
  output logic               shift_o,
  output logic               val_o,
  output logic               flg_lit_o,
  output lz77_pkg::byte_t    dat_lit_o,
  output lz77_pkg::len_t     dat_len_o,
  output lz77_pkg::dst_t     dat_dst_o,
  output logic               flg_lst_o,
  output logic               done_o
);

  import lz77_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_UPDATE,
    ST_SEARCH,
    ST_EMIT,
    ST_SHIFT
  } state_t;

  state_t   state_q;
  state_t   state_nxt;
  blk_len_t blk_len_q;
  blk_len_t cons_q;
  len_t     sh_cnt_q;
  logic     tok_last_q;
  logic     tok_lit_q;
  byte_t    tok_byte_q;
  len_t     tok_len_q;
  dst_t     tok_dst_q;
  len_t     len_sel;
  logic     last_sel;

  // a literal always consumes one byte
  assign len_sel  = is_lit_i ? len_t'(1) : best_len_i;
  assign last_sel = (cons_q + blk_len_t'(len_sel)) == blk_len_q;

  //----------------------------------------------------------
  // state machine
  //----------------------------------------------------------
  always_comb begin
    state_nxt = state_q;
    case (state_q)
      ST_IDLE:   if (start_i && (cfg_len_i != '0)) state_nxt = ST_UPDATE;
      ST_UPDATE: if (fill_done_i) state_nxt = ST_SEARCH;
      ST_SEARCH: if (srch_done_i) state_nxt = ST_EMIT;
      ST_EMIT:   state_nxt = ST_SHIFT;
      ST_SHIFT: begin
        if (sh_cnt_q == len_t'(1)) begin
          state_nxt = tok_last_q ? ST_IDLE : ST_UPDATE;
        end
      end
      default:   state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_q    <= ST_IDLE;
      blk_len_q  <= '0;
      cons_q     <= '0;
      sh_cnt_q   <= '0;
      tok_last_q <= 1'b0;
    end else begin
      state_q <= state_nxt;
      if ((state_q == ST_IDLE) && (state_nxt == ST_UPDATE)) begin
        blk_len_q <= cfg_len_i;
        cons_q    <= '0;
      end
      if ((state_q == ST_SEARCH) && srch_done_i) begin
        tok_last_q <= last_sel;
      end
      if (state_q == ST_EMIT) begin
        sh_cnt_q <= tok_len_q;
      end
      // one byte moves into the history per shift cycle
      if (shift_o) begin
        sh_cnt_q <= sh_cnt_q - len_t'(1);
        cons_q   <= cons_q + blk_len_t'(1);
      end
    end
  end

  //----------------------------------------------------------
  // token register
  //----------------------------------------------------------
  always_ff @(posedge clk) begin
    if ((state_q == ST_SEARCH) && srch_done_i) begin
      tok_lit_q  <= is_lit_i;
      tok_byte_q <= la_i;
      tok_len_q  <= len_sel;
      tok_dst_q  <= is_lit_i ? dst_t'(0) : best_dst_i;
    end
  end

  //----------------------------------------------------------
  // strobes and token fields
  //----------------------------------------------------------
  assign fill_en_o = state_q == ST_UPDATE;
  assign srch_go_o = fill_en_o && fill_done_i;
  assign shift_o   = state_q == ST_SHIFT;
  assign val_o     = state_q == ST_EMIT;

  // fields read as zero between tokens
  assign flg_lit_o = val_o && tok_lit_q;
  assign dat_lit_o = val_o ? tok_byte_q : byte_t'(0);
  assign dat_len_o = val_o ? tok_len_q : len_t'(0);
  assign dat_dst_o = val_o ? tok_dst_q : dst_t'(0);
  assign flg_lst_o = val_o && tok_last_q;
  assign done_o    = val_o && tok_last_q;

endmodule

`default_nettype wire

// File: hdl/lz77_fetch.sv
// source read issue for the lz77 compressor
// counts the block bytes still to fetch and keeps the lookahead topped up
// one-cycle read latency, returning data is pushed into the buffer

`timescale 1ns/1ps
`default_nettype none

module lz77_fetch #(
  parameter int MAX_LEN = lz77_pkg::DEF_MAX_LEN
) (
  input  logic               clk,
  input  logic               rstn,
  input  logic               start_i,
  input  lz77_pkg::blk_len_t cfg_len_i,
  input  logic               fill_en_i,
  input  lz77_pkg::len_t     la_cnt_i,
  output logic               src_rd_o,
  output logic               push_o,
  output logic               fill_done_o
);

  import lz77_pkg::*;

  blk_len_t   rem_q;
  logic       push_q;
  logic [4:0] la_pend;
  logic       room;
  logic       blk_idle;

  //----------------------------------------------------------
  // fill rule
  //----------------------------------------------------------
  // lookahead bytes held plus the read in flight
  assign la_pend = {1'b0, la_cnt_i} + {4'd0, push_q};
  assign room    = la_pend < 5'(MAX_LEN);

  // nothing left to fetch and everything fetched already consumed
  assign blk_idle = (rem_q == '0) && !push_q && (la_cnt_i == '0);

  assign src_rd_o    = fill_en_i && (rem_q != '0) && room;
  assign fill_done_o = fill_en_i && !push_q && ((rem_q == '0) || !room);
  assign push_o      = push_q;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rem_q  <= '0;
      push_q <= 1'b0;
    end else begin
      // data comes back one cycle after the read
      push_q <= src_rd_o;
      if (start_i && blk_idle) begin
        rem_q <= cfg_len_i;
      end else if (src_rd_o) begin
        rem_q <= rem_q - blk_len_t'(1);
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/lz77_match.sv
// longest match search for the lz77 compressor
// one candidate bit per distance, narrowed one byte position per cycle
// priority pick of the smallest surviving distance
// literal decision below the minimum length

`timescale 1ns/1ps
`default_nettype none

module lz77_match #(
  parameter int WIN_SIZE = lz77_pkg::DEF_WIN_SIZE,
  parameter int MAX_LEN  = lz77_pkg::DEF_MAX_LEN,
  parameter int MIN_LEN  = lz77_pkg::DEF_MIN_LEN
) (
  input  logic                           clk,
  input  logic                           rstn,
  input  logic                           srch_go_i,
  input  lz77_pkg::byte_t [WIN_SIZE-1:0] hist_i,
  input  lz77_pkg::byte_t [MAX_LEN-1:0]  la_i,
  input  lz77_pkg::dst_t                 win_cnt_i,
  input  lz77_pkg::len_t                 la_cnt_i,
  output logic                           srch_done_o,
  output lz77_pkg::len_t                 best_len_o,
  output lz77_pkg::dst_t                 best_dst_o,
  output logic                           is_lit_o
);

  import lz77_pkg::*;

  // bit j stands for distance j+1
  logic [WIN_SIZE-1:0] cand_q;
  logic [WIN_SIZE-1:0] cand_init;
  logic [WIN_SIZE-1:0] cand_nxt;
  logic                busy_q;
  len_t                k_q;
  byte_t               la_k;
  dst_t                pick_dst;
  logic                srch_end;
  len_t                best_len_q;
  dst_t                best_dst_q;

  //----------------------------------------------------------
  // candidate compare
  //----------------------------------------------------------
  // only distances inside the current history
  always_comb begin
    for (int j = 0; j < WIN_SIZE; j++) begin
      cand_init[j] = j < int'(win_cnt_i);
    end
  end

  // lookahead byte under test this cycle
  always_comb begin
    la_k = '0;
    for (int i = 0; i < MAX_LEN; i++) begin
      if (k_q == len_t'(i)) begin
        la_k = la_i[i];
      end
    end
  end

  // source byte k of distance j+1 sits at history offset j-k
  always_comb begin
    cand_nxt = cand_q;
    for (int j = 0; j < WIN_SIZE; j++) begin
      if (j < int'(k_q)) begin
        // source would run into the lookahead
        cand_nxt[j] = 1'b0;
      end else if (hist_i[j - int'(k_q)] != la_k) begin
        cand_nxt[j] = 1'b0;
      end
    end
  end

  // lowest set bit wins
  always_comb begin
    pick_dst = '0;
    for (int j = WIN_SIZE - 1; j >= 0; j--) begin
      if (cand_nxt[j]) begin
        pick_dst = dst_t'(j + 1);
      end
    end
  end

  //----------------------------------------------------------
  // search sequence
  //----------------------------------------------------------
  // early end on an empty candidate set or an exhausted lookahead
  assign srch_end = busy_q && ((cand_q == '0) || (k_q >= la_cnt_i));

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      busy_q     <= 1'b0;
      k_q        <= '0;
      cand_q     <= '0;
      best_len_q <= '0;
      best_dst_q <= '0;
    end else if (srch_go_i) begin
      busy_q     <= 1'b1;
      k_q        <= '0;
      cand_q     <= cand_init;
      best_len_q <= len_t'(1);
      best_dst_q <= '0;
    end else if (srch_end) begin
      busy_q <= 1'b0;
    end else if (busy_q) begin
      cand_q <= cand_nxt;
      k_q    <= k_q + len_t'(1);
      if (cand_nxt != '0) begin
        best_len_q <= k_q + len_t'(1);
        best_dst_q <= pick_dst;
      end
    end
  end

  assign srch_done_o = srch_end;
  assign best_len_o  = best_len_q;
  assign best_dst_o  = best_dst_q;
  assign is_lit_o    = best_len_q < len_t'(MIN_LEN);

endmodule

`default_nettype wire

// File: hdl/lz77_pkg.sv
// shared types and default sizes for the lz77 compressor
// byte, match length, match distance and block length vectors
// default window, longest and shortest match sizes

`default_nettype none

package lz77_pkg;

  //----------------------------------------------------------
  // data and field types
  //----------------------------------------------------------
  // one source byte
  typedef logic [7:0]  byte_t;

  // match length, up to 15
  typedef logic [3:0]  len_t;

  // match distance or history fill count, up to 31
  typedef logic [4:0]  dst_t;

  // byte count of one block
  typedef logic [15:0] blk_len_t;

  //----------------------------------------------------------
  // default sizes
  //----------------------------------------------------------
  // history depth in bytes
  localparam int DEF_WIN_SIZE = 16;

  // longest match, also the lookahead depth
  localparam int DEF_MAX_LEN  = 8;

  // below this a match is sent as a literal
  localparam int DEF_MIN_LEN  = 3;

endpackage

`default_nettype wire

// File: hdl/lz77_top.sv
// top level of the byte-serial lz77 compressor
// sets the sizes and connects fetch, buffer, match and control

`timescale 1ns/1ps
`default_nettype none

module lz77_top #(
  parameter int WIN_SIZE = lz77_pkg::DEF_WIN_SIZE,
  parameter int MAX_LEN  = lz77_pkg::DEF_MAX_LEN,
  parameter int MIN_LEN  = lz77_pkg::DEF_MIN_LEN
) (
  input  logic               clk,
  input  logic               rstn,
  input  logic               start_i,
  input  lz77_pkg::blk_len_t cfg_len_i,
  output logic               src_rd_o,
  input  lz77_pkg::byte_t    src_dat_i,
  output logic               val_o,
  output logic               flg_lit_o,
  output lz77_pkg::byte_t    dat_lit_o,
  output lz77_pkg::len_t     dat_len_o,
  output lz77_pkg::dst_t     dat_dst_o,
  output logic               flg_lst_o,
  output logic               done_o
);

  import lz77_pkg::*;

  logic                 fill_en;
  logic                 fill_done;
  logic                 push;
  logic                 shift;
  logic                 srch_go;
  logic                 srch_done;
  len_t                 best_len;
  dst_t                 best_dst;
  logic                 is_lit;
  byte_t [WIN_SIZE-1:0] hist;
  byte_t [MAX_LEN-1:0]  la;
  dst_t                 win_cnt;
  len_t                 la_cnt;

  //----------------------------------------------------------
  // pipeline peers
  //----------------------------------------------------------
  lz77_fetch #(.MAX_LEN(MAX_LEN)) lz77_fetch_i (
    .clk(clk), .rstn(rstn), .start_i(start_i), .cfg_len_i(cfg_len_i),
    .fill_en_i(fill_en), .la_cnt_i(la_cnt), .src_rd_o(src_rd_o),
    .push_o(push), .fill_done_o(fill_done)
  );

  lz77_buffer #(.WIN_SIZE(WIN_SIZE), .MAX_LEN(MAX_LEN)) lz77_buffer_i (
    .clk(clk), .rstn(rstn), .start_i(start_i), .push_i(push),
    .dat_i(src_dat_i), .shift_i(shift), .hist_o(hist), .la_o(la),
    .win_cnt_o(win_cnt), .la_cnt_o(la_cnt)
  );

  lz77_match #(.WIN_SIZE(WIN_SIZE), .MAX_LEN(MAX_LEN), .MIN_LEN(MIN_LEN)) lz77_match_i (
    .clk(clk), .rstn(rstn), .srch_go_i(srch_go), .hist_i(hist), .la_i(la),
    .win_cnt_i(win_cnt), .la_cnt_i(la_cnt), .srch_done_o(srch_done),
    .best_len_o(best_len), .best_dst_o(best_dst), .is_lit_o(is_lit)
  );

  lz77_ctrl lz77_ctrl_i (
    .clk(clk), .rstn(rstn), .start_i(start_i), .cfg_len_i(cfg_len_i),
    .fill_done_i(fill_done), .srch_done_i(srch_done), .best_len_i(best_len),
    .best_dst_i(best_dst), .is_lit_i(is_lit), .la_i(la[0]),
    .fill_en_o(fill_en), .srch_go_o(srch_go), .shift_o(shift), .val_o(val_o),
    .flg_lit_o(flg_lit_o), .dat_lit_o(dat_lit_o), .dat_len_o(dat_len_o),
    .dat_dst_o(dat_dst_o), .flg_lst_o(flg_lst_o), .done_o(done_o)
  );

endmodule

`default_nettype wire

// File: sim/lz77_asserts.sv
// concurrent checks on the lz77 top-level strobes
// single-cycle tokens, zero fields between tokens, match distance rule
// quiet outputs from reset until the first start

`timescale 1ns/1ps
`default_nettype none

module lz77_asserts (
  input logic            clk,
  input logic            rstn,
  input logic            start_i,
  input logic            src_rd_o,
  input logic            val_o,
  input logic            flg_lit_o,
  input lz77_pkg::byte_t dat_lit_o,
  input lz77_pkg::len_t  dat_len_o,
  input lz77_pkg::dst_t  dat_dst_o,
  input logic            flg_lst_o,
  input logic            done_o
);

  int   fail_cnt = 0;
  logic started_q;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      started_q <= 1'b0;
    end else if (start_i) begin
      started_q <= 1'b1;
    end
  end

  val_single: assert property (@(posedge clk) disable iff (!rstn)
    val_o |=> !val_o)
    else begin fail_cnt++; $error("val_o high for two cycles"); end

  fields_zero: assert property (@(posedge clk) disable iff (!rstn)
    !val_o |-> !flg_lit_o && dat_lit_o == '0 && dat_len_o == '0 &&
               dat_dst_o == '0 && !flg_lst_o)
    else begin fail_cnt++; $error("token fields not zero between tokens"); end

  match_dst: assert property (@(posedge clk) disable iff (!rstn)
    val_o && !flg_lit_o |-> dat_dst_o >= {1'b0, dat_len_o})
    else begin fail_cnt++; $error("match distance below its length"); end

  done_last: assert property (@(posedge clk) disable iff (!rstn)
    done_o |-> val_o && flg_lst_o)
    else begin fail_cnt++; $error("done_o without the last token"); end

  // nothing moves before the first block
  quiet_reset: assert property (@(posedge clk) disable iff (!rstn)
    !started_q |-> !src_rd_o && !val_o && !flg_lst_o && !done_o)
    else begin fail_cnt++; $error("strobe active before the first start"); end

endmodule

`default_nettype wire

// File: sim/lz77_tb.sv
// testbench for the lz77 compressor
// clock, reset, source memory model and greedy reference compressor
// token and read-count checks, watchdog and closing summary

`timescale 1ns/1ps
`default_nettype none

module lz77_tb;

  import lz77_pkg::*;

  localparam int WIN_SIZE = DEF_WIN_SIZE;
  localparam int MAX_LEN  = DEF_MAX_LEN;
  localparam int MIN_LEN  = DEF_MIN_LEN;
  localparam int NUM_BLK  = 40;
  localparam int MAX_BLK  = 60;
  localparam int SEED     = 32'hb5ef8863;

  typedef struct packed {
    logic  lit;
    byte_t dat;
    len_t  len;
    dst_t  dst;
    logic  last;
  } tok_t;

  logic     clk;
  logic     rstn;
  logic     start;
  blk_len_t cfg_len;
  logic     src_rd;
  byte_t    src_dat;
  logic     val;
  logic     flg_lit;
  byte_t    dat_lit;
  len_t     dat_len;
  dst_t     dat_dst;
  logic     flg_lst;
  logic     done;

  byte_t blk_mem [MAX_BLK];
  byte_t src_q [$];
  tok_t  exp_q [$];
  logic  rd_pend = 1'b0;
  logic  in_blk;
  int    rd_cnt = 0;
  int    rd_err_cnt = 0;
  int    mis_cnt;
  int    err_cnt;

  lz77_top #(
    .WIN_SIZE(WIN_SIZE), .MAX_LEN(MAX_LEN), .MIN_LEN(MIN_LEN)
  ) lz77_top_i (
    .clk(clk), .rstn(rstn), .start_i(start), .cfg_len_i(cfg_len),
    .src_rd_o(src_rd), .src_dat_i(src_dat), .val_o(val), .flg_lit_o(flg_lit),
    .dat_lit_o(dat_lit), .dat_len_o(dat_len), .dat_dst_o(dat_dst),
    .flg_lst_o(flg_lst), .done_o(done)
  );

  bind lz77_top lz77_asserts lz77_asserts_i (
    .clk(clk), .rstn(rstn), .start_i(start_i), .src_rd_o(src_rd_o),
    .val_o(val_o), .flg_lit_o(flg_lit_o), .dat_lit_o(dat_lit_o),
    .dat_len_o(dat_len_o), .dat_dst_o(dat_dst_o), .flg_lst_o(flg_lst_o),
    .done_o(done_o)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // generous bound per byte of the longest possible run
  initial begin
    repeat (NUM_BLK * MAX_BLK * (MAX_LEN + 12)) @(posedge clk);
    $display("timeout: the blocks did not complete in time");
    $display("*** FAILED ***");
    $finish;
  end

  //----------------------------------------------------------
  // source memory, one cycle read latency
  //----------------------------------------------------------
  // a read seen here completes on the next rising edge
  always @(negedge clk) begin
    if (rd_pend) begin
      assert (src_q.size() != 0) else begin
        rd_err_cnt++;
        $display("source read past the end of the block");
      end
      if (src_q.size() != 0) begin
        src_dat = src_q.pop_front();
      end
    end
    if (src_rd) begin
      rd_cnt++;
      assert (in_blk) else begin
        rd_err_cnt++;
        $display("source read while idle");
      end
    end
    rd_pend = src_rd;
  end

  //----------------------------------------------------------
  // reference compressor and checks
  //----------------------------------------------------------
  // greedy search, the smallest distance wins among equal lengths
  function automatic void build_expected(input int n);
    int   p;
    int   d;
    int   l;
    int   win;
    int   lim;
    int   bl;
    int   bd;
    tok_t t;
    exp_q.delete();
    p = 0;
    while (p < n) begin
      win = (p < WIN_SIZE) ? p : WIN_SIZE;
      lim = (n - p < MAX_LEN) ? n - p : MAX_LEN;
      bl = 0;
      bd = 0;
      for (d = 1; d <= win; d++) begin
        l = 0;
        while (l < lim && l < d && blk_mem[p - d + l] == blk_mem[p + l]) begin
          l++;
        end
        if (l > bl) begin
          bl = l;
          bd = d;
        end
      end
      t.dat = blk_mem[p];
      t.lit = bl < MIN_LEN;
      t.len = t.lit ? len_t'(1) : len_t'(bl);
      t.dst = t.lit ? dst_t'(0) : dst_t'(bd);
      p = p + int'(t.len);
      t.last = p == n;
      exp_q.push_back(t);
    end
  endfunction

  task automatic compare_field(input string name, input int got, input int want);
    assert (got == want) else begin
      mis_cnt++;
      $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, want);
    end
  endtask

  task automatic run_block(input int n);
    int   i;
    int   rd_base;
    int   sum;
    int   n_last;
    int   last_len;
    int   hist;
    logic seen_done;
    tok_t want;
    for (i = 0; i < n; i++) begin
      blk_mem[i] = 8'h61 + byte_t'($urandom % 4);
    end
    src_q.delete();
    for (i = 0; i < n; i++) begin
      src_q.push_back(blk_mem[i]);
    end
    build_expected(n);
    rd_base = rd_cnt;
    sum = 0;
    n_last = 0;
    last_len = 1;
    seen_done = 1'b0;
    start = 1'b1;
    cfg_len = blk_len_t'(n);
    in_blk = 1'b1;
    @(negedge clk);
    start = 1'b0;
    while (!seen_done) begin
      @(negedge clk);
      if (val) begin
        assert (exp_q.size() != 0) else begin
          err_cnt++;
          $display("token after the end of the expected stream");
        end
        if (exp_q.size() != 0) begin
          want = exp_q.pop_front();
          compare_field("flg_lit_o", int'(flg_lit), int'(want.lit));
          compare_field("dat_lit_o", int'(dat_lit), int'(want.dat));
          compare_field("dat_len_o", int'(dat_len), int'(want.len));
          compare_field("dat_dst_o", int'(dat_dst), int'(want.dst));
          compare_field("flg_lst_o", int'(flg_lst), int'(want.last));
          compare_field("done_o", int'(done), int'(want.last));
        end
        // source must lie in what this block already consumed
        hist = (sum < WIN_SIZE) ? sum : WIN_SIZE;
        assert (int'(dat_dst) <= hist) else begin
          mis_cnt++;
          $display("mismatch dat_dst_o: 0x%0h beyond history 0x%0h", dat_dst, hist);
        end
        sum += int'(dat_len);
        if (flg_lst) n_last++;
        if (done) begin
          seen_done = 1'b1;
          last_len = int'(dat_len);
        end
      end
    end
    assert (exp_q.size() == 0) else begin
      err_cnt++;
      $display("block ended with %0d tokens still expected", exp_q.size());
    end
    compare_field("dat_len_o sum", sum, n);
    compare_field("flg_lst_o count", n_last, 1);
    // the last token still shifts its bytes before idle
    repeat (last_len + 2) @(negedge clk);
    compare_field("src_rd_o count", rd_cnt - rd_base, n);
    in_blk = 1'b0;
    repeat ($urandom % 4) @(negedge clk);
  endtask

  //----------------------------------------------------------
  // main sequence
  //----------------------------------------------------------
  initial begin
    int asrt_cnt;
    mis_cnt = 0;
    err_cnt = 0;
    in_blk = 1'b0;
    rstn = 1'b0;
    start = 1'b0;
    cfg_len = '0;
    src_dat = '0;
    void'($urandom(SEED));
    repeat (4) @(negedge clk);
    rstn = 1'b1;
    repeat (2) @(negedge clk);
    for (int b = 0; b < NUM_BLK; b++) begin
      run_block(1 + int'($urandom % MAX_BLK));
    end
    repeat (4) @(negedge clk);
    asrt_cnt = lz77_top_i.lz77_asserts_i.fail_cnt;
    $display("errors: %0d mismatch, %0d other, %0d source, %0d assertion",
             mis_cnt, err_cnt, rd_err_cnt, asrt_cnt);
    if (mis_cnt + err_cnt + rd_err_cnt + asrt_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
